/* vlog.f */
design/link_pkg.sv
design/emesh_pkg.sv
design/erx_sampler.sv
design/erx_unpack.sv
design/erx_fifo.sv
design/erx_top.sv
test/tb_erx.sv

/* Makefile */
# Verilator build and run for the erx receiver

VERILATOR ?= verilator
TOP       ?= tb_erx
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SRCS      := $(wildcard design/*.sv test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Simulation failed" $(LOG) || [ $$status -ne 0 ]; then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/tb_erx.sv */
`timescale 1ns/10ps

module tb_erx;

   localparam int N_STIM = 16;

   // one row of the stimulus table
   typedef struct packed {
      logic             write;
      emesh_pkg::mode_t datamode;
      emesh_pkg::ctrl_t ctrlmode;
      emesh_pkg::addr_t dstaddr;
      emesh_pkg::data_t data;
      emesh_pkg::addr_t srcaddr;
      logic [3:0]       follow;   // packets after this one in the same frame
      logic [7:0]       ready;    // out_ready pattern, one bit per cycle
   } stim_t;

   logic                rx_lclk;
   logic                reset;
   link_pkg::link_in_t  link;
   emesh_pkg::rx_item_t out_item;
   logic                out_valid;
   logic                out_ready;
   logic                wr_wait;
   logic                overflow;

   stim_t               stim [N_STIM];
   string               names [N_STIM];
   emesh_pkg::rx_item_t exp_q [$];   // scoreboard, in link order
   string               name_q [$];
   logic [7:0]          ready_mask;
   logic [2:0]          ready_phase;
   integer              seed;
   int                  errors = 0;
   int                  checked = 0;
   int                  cycles = 0;
   int                  cycle_limit;
   logic                saw_wait = 1'b0;   // pushback seen at least once

   erx_top erx_top_inst
      (
      .rx_lclk   (rx_lclk),
      .reset     (reset),
      .link      (link),
      .out_item  (out_item),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .wr_wait   (wr_wait),
      .overflow  (overflow)
      );

   initial
   begin
      rx_lclk = 1'b0;
      forever #20 rx_lclk = ~rx_lclk;   // 40 ns period
   end

   //########################################
   // checks and scoreboard
   //########################################
   task automatic check_value(input string test, input string field,
                              input logic [31:0] want, input logic [31:0] act);
      assert (act === want) else
      begin
         errors++;
         $display("[FAIL] %s %s expected %h actual %h", test, field, want, act);
      end
   endtask

   task automatic check_item(input emesh_pkg::rx_item_t got);
      emesh_pkg::rx_item_t want;
      string               test;
      checked++;   // every transfer, pending or not
      assert (exp_q.size() > 0) else
      begin
         errors++;
         $display("an item came out of the receiver while none was pending");
      end
      if (exp_q.size() > 0)
      begin
         want = exp_q.pop_front();
         test = name_q.pop_front();
         check_value(test, "access", 32'(want.packet.access), 32'(got.packet.access));
         check_value(test, "write", 32'(want.packet.write), 32'(got.packet.write));
         check_value(test, "datamode", 32'(want.packet.datamode), 32'(got.packet.datamode));
         check_value(test, "ctrlmode", 32'(want.packet.ctrlmode), 32'(got.packet.ctrlmode));
         check_value(test, "dstaddr", want.packet.dstaddr, got.packet.dstaddr);
         check_value(test, "data", want.packet.data, got.packet.data);
         check_value(test, "srcaddr", want.packet.srcaddr, got.packet.srcaddr);
         check_value(test, "burst", 32'(want.burst), 32'(got.burst));
      end
   endtask

   // one transfer per edge with valid and ready high
   always @(posedge rx_lclk)
   begin
      if (!reset && out_valid && out_ready)
         check_item(out_item);
   end

   always @(posedge rx_lclk)
   begin
      cycles++;
      if (cycles > cycle_limit)
      begin
         $display("timeout after %0d cycles, the packets never drained", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   //########################################
   // table and link driver
   //########################################
   task automatic add_row(input int idx, input string name, input logic wr,
                          input emesh_pkg::mode_t mode, input emesh_pkg::ctrl_t ctrl,
                          input emesh_pkg::addr_t dst, input logic [3:0] follow,
                          input logic [7:0] ready);
      names[idx]         = name;
      stim[idx].write    = wr;
      stim[idx].datamode = mode;
      stim[idx].ctrlmode = ctrl;
      stim[idx].dstaddr  = dst;
      stim[idx].data     = $random(seed);
      stim[idx].srcaddr  = $random(seed);
      stim[idx].follow   = follow;
      stim[idx].ready    = ready;
   endtask

   task automatic fill_table();
      add_row(0, "single_wr", 1'b1, 2'd2, 4'h0, 32'h8000_1234, 4'd0, 8'hFF);
      add_row(1, "single_rd", 1'b0, 2'd1, 4'h5, 32'h0ABC_DEF7, 4'd0, 8'hFF);
      add_row(2, "b2b_0", 1'b1, 2'd3, 4'hA, 32'h1234_5678, 4'd0, 8'b1011_0110);
      add_row(3, "b2b_1", 1'b0, 2'd0, 4'h3, 32'hFEDC_BA98, 4'd0, 8'b1011_0110);
      add_row(4, "b2b_2", 1'b1, 2'd2, 4'hF, 32'h5A5A_A5A5, 4'd0, 8'b0110_1101);
      add_row(5, "burst_lead", 1'b1, 2'd2, 4'h6, 32'h2000_0049, 4'd3, 8'hFF);
      for (int k = 6; k < 9; k++)   // header fields come from the leader
         add_row(k, $sformatf("burst_f%0d", k - 5), 1'b0, 2'd0, 4'h0, 32'h0, 4'd0, 8'hFF);
      for (int k = 9; k < N_STIM; k++)   // consumer stalled
         add_row(k, $sformatf("stall_%0d", k - 9), k[0], 2'd2, 4'h1,
                 32'h4000_0000 + 32'(4 * k), 4'd0, 8'h00);
   endtask

   // inverse of the field map, beat 0 in the low bits
   function automatic link_pkg::sample_t pack_beats(input stim_t s);
      link_pkg::sample_t smp;
      smp          = '0;
      smp[11:8]    = s.dstaddr[31:28];
      smp[15:12]   = s.ctrlmode;
      smp[23:16]   = s.dstaddr[27:20];
      smp[31:24]   = s.dstaddr[19:12];
      smp[39:32]   = s.dstaddr[11:4];
      smp[40]      = 1'b1;   // access
      smp[41]      = s.write;
      smp[43:42]   = s.datamode;
      smp[47:44]   = s.dstaddr[3:0];
      smp[79:48]   = {s.data[7:0], s.data[15:8], s.data[23:16], s.data[31:24]};
      smp[111:80]  = {s.srcaddr[7:0], s.srcaddr[15:8], s.srcaddr[23:16], s.srcaddr[31:24]};
      return smp;
   endfunction

   // beat 2 is not resent in a burst so dstaddr stays with the leader
   function automatic emesh_pkg::rx_item_t expect_item(input stim_t hdr, input stim_t body,
                                                       input logic burst);
      emesh_pkg::rx_item_t e;
      e.packet.access   = 1'b1;
      e.packet.write    = hdr.write;
      e.packet.datamode = hdr.datamode;
      e.packet.ctrlmode = hdr.ctrlmode;
      e.packet.dstaddr  = hdr.dstaddr;
      e.packet.data     = body.data;
      e.packet.srcaddr  = body.srcaddr;
      e.burst           = burst;
      return e;
   endfunction

   // every input changes here, on the falling edge
   task automatic next_cycle();
      @(negedge rx_lclk);
      out_ready   = ready_mask[ready_phase];
      ready_phase = ready_phase + 3'd1;
   endtask

   task automatic send_beat(input link_pkg::beat_t beat);
      next_cycle();
      link.frame = 1'b1;
      link.data  = beat;
   endtask

   task automatic idle(input int n);
      repeat (n)
      begin
         next_cycle();
         link = '0;
      end
   endtask

   task automatic send_frame(input int first);
      link_pkg::sample_t smp;
      stim_t             lead;
      int                pause;
      lead       = stim[first];
      ready_mask = lead.ready;
      pause      = 0;
      while (wr_wait)   // no new frame under pushback
      begin
         saw_wait = 1'b1;
         pause++;
         if (pause > 12)
            ready_mask = 8'hFF;   // consumer returns
         next_cycle();
      end
      smp = pack_beats(lead);
      for (int b = 0; b < link_pkg::BEATS; b++)
         send_beat(smp[b*link_pkg::BEAT_W +: link_pkg::BEAT_W]);
      exp_q.push_back(expect_item(lead, lead, 1'b0));
      name_q.push_back(names[first]);
      for (int k = 1; k <= int'(lead.follow); k++)
      begin
         assert (!wr_wait) else
         begin
            errors++;
            $display("wr_wait rose in the middle of a burst frame");
         end
         smp = pack_beats(stim[first + k]);
         for (int b = link_pkg::BURST_FIRST; b < link_pkg::BEATS; b++)
            send_beat(smp[b*link_pkg::BEAT_W +: link_pkg::BEAT_W]);
         exp_q.push_back(expect_item(lead, stim[first + k], 1'b1));
         name_q.push_back(names[first + k]);
      end
      idle(2);   // frame low, next frame gets a fresh edge
   endtask

   //########################################
   // main sequence
   //########################################
   initial
   begin
      int rem;
      int i;
      seed        = 31;
      reset       = 1'b1;
      link        = '0;
      out_ready   = 1'b0;
      ready_mask  = 8'hFF;
      ready_phase = 3'd0;
      fill_table();
      cycle_limit = 200;   // 12 cycles per beat on top
      rem         = 0;
      for (int r = 0; r < N_STIM; r++)
      begin
         if (rem > 0)
         begin
            cycle_limit += 12 * 4;   // burst follower
            rem--;
         end
         else
         begin
            cycle_limit += 12 * link_pkg::BEATS;
            rem = int'(stim[r].follow);
         end
      end
      repeat (3) @(posedge rx_lclk);
      @(negedge rx_lclk);
      reset = 1'b0;
      repeat (5)   // idle link after reset
      begin
         next_cycle();
         check_value("after_reset", "out_valid", 32'h0, 32'(out_valid));
         check_value("after_reset", "wr_wait", 32'h0, 32'(wr_wait));
         check_value("after_reset", "overflow", 32'h0, 32'(overflow));
      end
      i = 0;
      while (i < N_STIM)
      begin
         send_frame(i);
         i += 1 + int'(stim[i].follow);
      end
      ready_mask = 8'hFF;
      while (exp_q.size() > 0)
         next_cycle();
      idle(6);   // room for a stray duplicate
      check_value("final", "overflow", 32'h0, 32'(overflow));
      check_value("final", "item_count", 32'(N_STIM), 32'(checked));
      assert (saw_wait) else
      begin
         errors++;
         $display("wr_wait never rose while out_ready was held low");
      end
      $display("items checked %0d, errors %0d", checked, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

/* design/erx_top.sv */
`timescale 1ns/10ps

module erx_top
   (
   input  logic                rx_lclk,
   input  logic                reset,
   input  link_pkg::link_in_t  link,
   output emesh_pkg::rx_item_t out_item,
   output logic                out_valid,
   input  logic                out_ready,
   output logic                wr_wait,
   output logic                overflow
   );

   link_pkg::sample_t   sample;
   logic                sample_done;
   logic                sample_burst;
   emesh_pkg::rx_item_t item;
   logic                item_valid;

   // beats to raw sample
   erx_sampler erx_sampler_inst
      (
      .rx_lclk      (rx_lclk),
      .reset        (reset),
      .link         (link),
      .sample       (sample),
      .sample_done  (sample_done),
      .sample_burst (sample_burst)
      );

   // raw sample to mesh packet
   erx_unpack erx_unpack_inst
      (
      .rx_lclk      (rx_lclk),
      .reset        (reset),
      .sample       (sample),
      .sample_done  (sample_done),
      .sample_burst (sample_burst),
      .item         (item),
      .item_valid   (item_valid)
      );

   // buffer plus write wait
   erx_fifo erx_fifo_inst
      (
      .rx_lclk    (rx_lclk),
      .reset      (reset),
      .item       (item),
      .item_valid (item_valid),
      .out_item   (out_item),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .wr_wait    (wr_wait),
      .overflow   (overflow)
      );

endmodule

/* design/erx_fifo.sv */
`timescale 1ns/10ps

module erx_fifo
   (
   input  logic                rx_lclk,
   input  logic                reset,
   input  emesh_pkg::rx_item_t item,
   input  logic                item_valid,
   output emesh_pkg::rx_item_t out_item,
   output logic                out_valid,
   input  logic                out_ready,
   output logic                wr_wait,
   output logic                overflow
   );

   emesh_pkg::rx_item_t  mem [emesh_pkg::FIFO_DEPTH];
   emesh_pkg::fifo_ptr_t wr_ptr;
   emesh_pkg::fifo_ptr_t rd_ptr;
   emesh_pkg::fifo_cnt_t count;   // entries held
   logic                 full;
   logic                 wr_en;
   logic                 rd_en;

   //########################################
   // status and handshake
   //########################################
   assign full      = (count == emesh_pkg::fifo_cnt_t'(emesh_pkg::FIFO_DEPTH));
   assign out_valid = (count != '0);
   assign out_item  = mem[rd_ptr];         // head of queue
   assign rd_en     = out_valid & out_ready;
   assign wr_en     = item_valid & ~full;  // link cannot stall, drop instead

   // storage
   always_ff @(posedge rx_lclk)
   begin
      if (wr_en)
         mem[wr_ptr] <= item;
   end

   //########################################
   // pointers, count, pushback
   //########################################
   always_ff @(posedge rx_lclk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         wr_wait  <= 1'b0;
         overflow <= 1'b0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;

         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or none
         endcase

         // early warning, sender may still finish its packet
         wr_wait <= (count >= emesh_pkg::fifo_cnt_t'(emesh_pkg::WAIT_LEVEL));

         if (item_valid & full)
            overflow <= 1'b1;   // sticky until reset
      end
   end

endmodule

/* design/erx_unpack.sv */
`timescale 1ns/10ps

module erx_unpack
   (
   input  logic                rx_lclk,
   input  logic                reset,
   input  link_pkg::sample_t   sample,
   input  logic                sample_done,
   input  logic                sample_burst,
   output emesh_pkg::rx_item_t item,
   output logic                item_valid
   );

   logic [emesh_pkg::PW-1:0] packet_flat;   // reordered sample

   //########################################
   // field map, sample to mesh packet
   //########################################
   assign packet_flat = {
      // srcaddr, msb byte first
      sample[87:80],
      sample[95:88],
      sample[103:96],
      sample[111:104],
      // data
      sample[55:48],
      sample[63:56],
      sample[71:64],
      sample[79:72],
      // dstaddr split over beats 0 to 2
      sample[11:8],
      sample[23:16],
      sample[31:24],
      sample[39:32],
      sample[47:44],
      sample[15:12],   // ctrlmode
      sample[43:42],   // datamode
      sample[41],      // write
      sample[40]       // access
   };

   // one cycle after the done strobe
   always_ff @(posedge rx_lclk or posedge reset)
   begin
      if (reset)
         item_valid <= 1'b0;
      else
         item_valid <= sample_done;
   end

   // hold until the next packet
   always_ff @(posedge rx_lclk)
   begin
      if (sample_done)
      begin
         item.packet <= emesh_pkg::packet_t'(packet_flat);
         item.burst  <= sample_burst;   // tag from the sampler
      end
   end

endmodule

/* design/erx_sampler.sv */
`timescale 1ns/10ps

module erx_sampler
   (
   input  logic               rx_lclk,
   input  logic               reset,
   input  link_pkg::link_in_t link,
   output link_pkg::sample_t  sample,
   output logic               sample_done,
   output logic               sample_burst
   );

   logic               frame_reg;   // frame at the first flop
   logic               frame_old;   // one beat later
   link_pkg::beat_t    data_reg;
   logic               new_tran;    // rising edge of frame
   link_pkg::pointer_t pointer;     // slot for the next beat
   logic               last_beat;
   logic               cont;        // next sample is a burst follower

   //########################################
   // frame edge detector
   //########################################
   always_ff @(posedge rx_lclk or posedge reset)
   begin
      if (reset)
      begin
         frame_reg <= 1'b0;
         frame_old <= 1'b0;
      end
      else
      begin
         frame_reg <= link.frame;
         frame_old <= frame_reg;
      end
   end

   always_ff @(posedge rx_lclk)
      data_reg <= link.data;   // beat payload

   assign new_tran = frame_reg & ~frame_old;

   //########################################
   // write pointer
   //########################################
   // idle parks the pointer on slot 0, so a fresh frame always lands there
   assign last_beat = frame_reg & pointer[link_pkg::BEATS-1];

   always_ff @(posedge rx_lclk or posedge reset)
   begin
      if (reset)
         pointer <= link_pkg::PTR_FIRST;
      else if (!frame_reg)
         pointer <= link_pkg::PTR_FIRST;   // idle, wait at beat 0
      else if (pointer[link_pkg::BEATS-1])
         pointer <= link_pkg::PTR_BURST;   // anticipate a burst
      else
         pointer <= pointer << 1;          // middle of frame
   end

   // 112 bit sample, one 16 bit slot per beat
   always_ff @(posedge rx_lclk)
   begin
      if (frame_reg)
         for (int i = 0; i < link_pkg::BEATS; i++)
            if (pointer[i])
               sample[i*link_pkg::BEAT_W +: link_pkg::BEAT_W] <= data_reg;
   end

   //########################################
   // done strobe and burst tag
   //########################################
   always_ff @(posedge rx_lclk or posedge reset)
   begin
      if (reset)
      begin
         sample_done  <= 1'b0;
         sample_burst <= 1'b0;
         cont         <= 1'b0;
      end
      else
      begin
         sample_done <= last_beat;   // one pulse per packet
         if (last_beat)
            sample_burst <= cont;
         // frame still up after the last beat means more packets follow
         if (new_tran)
            cont <= 1'b0;
         else if (sample_done & frame_reg)
            cont <= 1'b1;
      end
   end

endmodule

/* design/emesh_pkg.sv */
//########################################
// mesh packet format and rx buffering
//########################################

package emesh_pkg;

   localparam int PW = 104;   // flat packet width

   typedef logic [31:0] addr_t;   // dstaddr / srcaddr
   typedef logic [31:0] data_t;
   typedef logic [1:0]  mode_t;   // datamode, byte to double
   typedef logic [3:0]  ctrl_t;   // ctrlmode

   // access in bit 0, srcaddr on top
   typedef struct packed {
      addr_t srcaddr;
      data_t data;
      addr_t dstaddr;
      ctrl_t ctrlmode;
      mode_t datamode;
      logic  write;
      logic  access;
   } packet_t;

   // one fifo entry
   typedef struct packed {
      packet_t packet;
      logic    burst;   // follower inside a burst frame
   } rx_item_t;

   //########################################
   // output fifo
   //########################################
   localparam int FIFO_DEPTH = 8;
   localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
   localparam int WAIT_LEVEL = 5;   // room left for packets in flight

   typedef logic [FIFO_AW-1:0] fifo_ptr_t;   // wraps by itself
   typedef logic [FIFO_AW:0]   fifo_cnt_t;   // 0 to FIFO_DEPTH

endpackage

/* design/link_pkg.sv */
//########################################
// link side of the receiver
//########################################

package link_pkg;

   localparam int BEAT_W      = 16;   // bits per link beat
   localparam int BEATS       = 7;    // beats in a full packet
   localparam int BURST_FIRST = 3;    // first beat rewritten in a burst

   // one beat as it leaves the pad logic
   typedef logic [BEAT_W-1:0]       beat_t;

   // one-hot slot select, bit i writes beat i
   typedef logic [BEATS-1:0]        pointer_t;

   // raw sample, beat 0 in the low bits
   typedef logic [BEATS*BEAT_W-1:0] sample_t;

   localparam pointer_t PTR_FIRST = pointer_t'(1);                // slot of beat 0
   localparam pointer_t PTR_BURST = pointer_t'(1 << BURST_FIRST); // restart point in a burst

   // pins after the pad logic
   typedef struct packed {
      logic  frame;   // high for every beat of a transfer
      beat_t data;
   } link_in_t;

endpackage
